//--- rtl/lcd_consts.svh
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// cycles per delay at the board clock
`define LCD_DELAY_CYCLES 40000

// four commands plus "HELLO WORLD"
`define LCD_NUM_STEPS 15

// HD44780 command bytes
`define LCD_CMD_FUNCTION_SET 8'h3C   // 8-bit bus, 2 lines, 5x10 font
`define LCD_CMD_DISPLAY_CTRL 8'h0F   // display, cursor and blink on
`define LCD_CMD_CLEAR        8'h01

`define LCD_RESET_DATA 8'h3C   // value on the data pins out of reset

// clear needs the extra settle delay after it
`define LCD_CLEAR_STEP 3

`endif

//--- rtl/lcd_pkg.sv
package lcd_pkg;

    // one byte on the LCD data bus
    typedef logic [7:0] lcd_byte_t;

    // index into the write sequence, 0 to 14
    typedef logic [3:0] step_idx_t;

    // wide enough for the 40000 cycle power-up delay
    typedef logic [15:0] delay_count_t;

    // what a single step puts on the bus
    typedef struct packed {
        logic      rs;    // 0 = command, 1 = character
        lcd_byte_t data;
    } lcd_step_t;

    // registered pin values toward the LCD
    typedef struct packed {
        logic      e;
        logic      rs;
        lcd_byte_t data;
    } lcd_bus_t;

    // sequencer states
    typedef enum logic [2:0] {
        WAKE,     // power-up delay
        ISSUE,    // load the bus and raise e
        WAIT,     // e low, command executing
        SETTLE,   // extra delay after clear
        DONE      // parked, e low
    } seq_state_t;

endpackage

//--- rtl/lcd_delay_timer.sv
`include "lcd_consts.svh"

// counts while timing is high and flags the last cycle of each delay
module lcd_delay_timer
    import lcd_pkg::*;
#(
    parameter int unsigned delay_cycles = `LCD_DELAY_CYCLES  // needs to be 2 or more
)
(
    input  logic clkout,
    input  logic reset,
    input  logic timing,
    output logic elapsed
);

    localparam delay_count_t last_count = delay_count_t'(delay_cycles - 1);

    delay_count_t count;

    // high on the delay_cycles-th cycle of a run
    assign elapsed = timing && (count == last_count);

    always_ff @(posedge clkout or posedge reset)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (!timing)
        begin
            count <= '0;    // idle, hold at zero
        end
        else if (count == last_count)
        begin
            count <= '0;    // back to back delays restart here
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    // a run always needs at least one cycle of counting before it can finish
    elapsed_after_timing: assert property (
        @(posedge clkout) disable iff (reset)
        elapsed |-> $past(timing)
    )
    else $error("elapsed raised without timing in the previous cycle");

endmodule

//--- rtl/lcd_step_rom.sv
`include "lcd_consts.svh"

// fixed table of bus writes, commands first and then the text
module lcd_step_rom
    import lcd_pkg::*;
(
    input  step_idx_t step,
    output lcd_step_t entry
);

    always_comb
    begin
        case (step)
            // init commands, rs low
            4'd0:
                entry = '{rs: 1'b0, data: `LCD_CMD_FUNCTION_SET};
            4'd1:
                entry = '{rs: 1'b0, data: `LCD_CMD_FUNCTION_SET};  // repeated on purpose
            4'd2:
                entry = '{rs: 1'b0, data: `LCD_CMD_DISPLAY_CTRL};
            4'd3:
                entry = '{rs: 1'b0, data: `LCD_CMD_CLEAR};

            // text, rs high
            4'd4:
                entry = '{rs: 1'b1, data: "H"};
            4'd5:
                entry = '{rs: 1'b1, data: "E"};
            4'd6:
                entry = '{rs: 1'b1, data: "L"};
            4'd7:
                entry = '{rs: 1'b1, data: "L"};
            4'd8:
                entry = '{rs: 1'b1, data: "O"};
            4'd9:
                entry = '{rs: 1'b1, data: " "};
            4'd10:
                entry = '{rs: 1'b1, data: "W"};
            4'd11:
                entry = '{rs: 1'b1, data: "O"};
            4'd12:
                entry = '{rs: 1'b1, data: "R"};
            4'd13:
                entry = '{rs: 1'b1, data: "L"};
            4'd14:
                entry = '{rs: 1'b1, data: "D"};

            // index 15 is never issued
            default:
                entry = '{rs: 1'b0, data: `LCD_RESET_DATA};
        endcase
    end

endmodule

//--- rtl/lcd_sequencer.sv
`include "lcd_consts.svh"

// walks the step table, one enable pulse per step with a delay after each
module lcd_sequencer
    import lcd_pkg::*;
(
    input  logic      clkout,
    input  logic      reset,
    input  logic      elapsed,
    input  lcd_step_t entry,
    output logic      timing,
    output step_idx_t step,
    output lcd_bus_t  bus
);

    localparam step_idx_t last_step  = step_idx_t'(`LCD_NUM_STEPS - 1);
    localparam step_idx_t clear_step = step_idx_t'(`LCD_CLEAR_STEP);

    seq_state_t state;

    // the timer runs in every waiting state
    assign timing = (state == WAKE) || (state == WAIT) || (state == SETTLE);

    // state and step counter
    always_ff @(posedge clkout or posedge reset)
    begin
        if (reset)
        begin
            state <= WAKE;
            step  <= '0;
        end
        else
        begin
            case (state)
                WAKE:
                begin
                    if (elapsed)
                    begin
                        state <= ISSUE;
                    end
                end

                ISSUE:
                begin
                    state <= WAIT;    // e goes high on this edge
                end

                WAIT:
                begin
                    if (elapsed)
                    begin
                        if (step == last_step)
                        begin
                            state <= DONE;
                        end
                        else
                        begin
                            step <= step + 1'b1;
                            // clear takes far longer than the other commands
                            if (step == clear_step)
                            begin
                                state <= SETTLE;
                            end
                            else
                            begin
                                state <= ISSUE;
                            end
                        end
                    end
                end

                SETTLE:
                begin
                    if (elapsed)
                    begin
                        state <= ISSUE;
                    end
                end

                DONE:
                begin
                    state <= DONE;    // stays until the next reset
                end

                default:
                begin
                    state <= WAKE;
                end
            endcase
        end
    end

    // bus register, e is high for the one cycle after ISSUE
    always_ff @(posedge clkout or posedge reset)
    begin
        if (reset)
        begin
            bus <= '{e: 1'b0, rs: 1'b0, data: `LCD_RESET_DATA};
        end
        else
        begin
            case (state)
                ISSUE:
                begin
                    bus <= '{e: 1'b1, rs: entry.rs, data: entry.data};
                end

                DONE:
                begin
                    bus.e  <= 1'b0;
                    bus.rs <= 1'b0;    // data keeps the last character
                end

                default:
                begin
                    bus.e <= 1'b0;     // rs and data hold through the delay
                end
            endcase
        end
    end

    // every write is a single-cycle enable pulse
    e_single_cycle: assert property (
        @(posedge clkout) disable iff (reset)
        bus.e |=> !bus.e
    )
    else $error("enable held high for more than one cycle");

    step_in_range: assert property (
        @(posedge clkout) disable iff (reset)
        step <= last_step
    )
    else $error("step index ran past the last step");

endmodule

//--- rtl/lcd_top.sv
`include "lcd_consts.svh"

// HD44780 driver, initialises the display and prints HELLO WORLD
module lcd_top
    import lcd_pkg::*;
#(
    parameter int unsigned delay_cycles = `LCD_DELAY_CYCLES
)
(
    input  logic      clkout,
    input  logic      reset,
    output lcd_byte_t data,
    output logic      e,
    output logic      rs,
    output logic      r_nw
);

    logic      timing;
    logic      elapsed;
    step_idx_t step;
    lcd_step_t entry;
    lcd_bus_t  bus;

    lcd_delay_timer #(
        .delay_cycles (delay_cycles)
    ) u_timer (
        .clkout  (clkout),
        .reset   (reset),
        .timing  (timing),
        .elapsed (elapsed)
    );

    lcd_step_rom u_rom (
        .step  (step),
        .entry (entry)
    );

    lcd_sequencer u_seq (
        .clkout  (clkout),
        .reset   (reset),
        .elapsed (elapsed),
        .entry   (entry),
        .timing  (timing),
        .step    (step),
        .bus     (bus)
    );

    // pins come straight from the bus register
    assign data = bus.data;
    assign e    = bus.e;
    assign rs   = bus.rs;
    assign r_nw = 1'b0;    // write only, busy flag never read

endmodule

//--- verification/lcd_bus_checker.sv
// watches the LCD pins and scores each enable pulse against the expected step
module lcd_bus_checker
    import lcd_pkg::*;
(
    input  logic      clkout,
    input  logic      reset,
    input  lcd_byte_t data,
    input  logic      e,
    input  logic      rs,
    input  logic      r_nw,
    input  logic      armed,      // a step is expected on the next rise
    input  lcd_byte_t exp_data,
    input  logic      exp_rs,
    input  int        exp_gap,    // cycles since the previous rise of e
    input  logic      idle_req,
    output int        tests_done,
    output int        pass_count,
    output int        fail_count
);

    timeunit 1ns;
    timeprecision 100ps;

    int        gap;           // cycles since reset release or the last rise
    int        pulse_no;
    int        test_errors;
    logic      prev_e;
    logic      prev_reset;
    logic      pending;       // rise seen, width still to check
    lcd_byte_t seen_data;
    logic      seen_rs;
    int        seen_gap;

    initial
    begin
        tests_done  = 0;
        pass_count  = 0;
        fail_count  = 0;
        gap         = 0;
        pulse_no    = 0;
        test_errors = 0;
        prev_e      = 1'b0;
        prev_reset  = 1'b0;
        pending     = 1'b0;
    end

    task automatic report_error(input string msg);
        test_errors = test_errors + 1;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0)
        begin
            pass_count = pass_count + 1;
            $display("%s ok", name);
        end
        else
        begin
            fail_count = fail_count + 1;
            $display("%s FAILED with %0d mismatches", name, test_errors);
        end
        tests_done  = tests_done + 1;
        test_errors = 0;
    endtask

    // async reset, so the pins must already show their reset values
    task automatic check_reset_pins();
        if (e !== 1'b0)
            report_error("e not low during reset");
        if (rs !== 1'b0)
            report_error("rs not low during reset");
        if (r_nw !== 1'b0)
            report_error("r_nw not low during reset");
        if (data !== 8'h3C)
            report_error($sformatf("data 0x%02h during reset, expected 0x%02h",
                                   data, 8'h3C));
        close_test("pins during reset");
    endtask

    task automatic check_rise();
        pulse_no = pulse_no + 1;
        if (!armed)
        begin
            fail_count = fail_count + 1;
            $display("enable pulse %0d at %0d ns came when no write was expected",
                     pulse_no, $time);
        end
        else
        begin
            seen_data = data;
            seen_rs   = rs;
            seen_gap  = gap;
            if (data !== exp_data)
                report_error($sformatf("pulse %0d data 0x%02h, expected 0x%02h",
                                       pulse_no, data, exp_data));
            if (rs !== exp_rs)
                report_error($sformatf("pulse %0d rs %0b, expected %0b", pulse_no, rs, exp_rs));
            if (r_nw !== 1'b0)
                report_error($sformatf("pulse %0d r_nw high", pulse_no));
            if (gap != exp_gap)
                report_error($sformatf("pulse %0d came %0d cycles after the last one, expected %0d",
                                       pulse_no, gap, exp_gap));
            pending = 1'b1;
        end
    endtask

    task automatic check_width();
        if (e !== 1'b0)
            report_error($sformatf("pulse %0d e still high in its second cycle", pulse_no));
        close_test($sformatf("pulse %0d data 0x%02h rs %0b after %0d cycles",
                             pulse_no, seen_data, seen_rs, seen_gap));
        pending = 1'b0;
    endtask

    task automatic check_idle();
        if (gap < exp_gap)
            report_error($sformatf("only %0d quiet cycles after the last pulse, expected %0d",
                                   gap, exp_gap));
        if (e !== 1'b0)
            report_error("e high while parked");
        if (rs !== 1'b0)
            report_error("rs high while parked");
        if (r_nw !== 1'b0)
            report_error("r_nw high while parked");
        if (data !== exp_data)
            report_error($sformatf("parked data 0x%02h, expected 0x%02h", data, exp_data));
        close_test("idle after the last character");
    endtask

    // pins change on the nonblocking update, so the edge sees settled values
    always @(posedge clkout)
    begin
        if (reset)
        begin
            if (!prev_reset)
                check_reset_pins();
            gap      = 0;
            pulse_no = 0;
            pending  = 1'b0;
        end
        else
        begin
            gap = gap + 1;
            if (pending)
                check_width();
            if (e === 1'b1 && prev_e !== 1'b1)
            begin
                check_rise();
                gap = 0;    // next gap counts from this rise
            end
            if (idle_req)
                check_idle();
        end
        prev_e     = e;
        prev_reset = reset;
    end

endmodule

//--- verification/lcd_tb.sv
`include "lcd_consts.svh"

module lcd_tb
    import lcd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int delay        = 20;
    localparam int clk_period   = 4;
    localparam int reset_cycles = 3;
    localparam int num_rows     = `LCD_NUM_STEPS;

    // one expected write on the bus
    typedef struct packed {
        lcd_byte_t data;
        logic      rs;
        int        gap;    // cycles since the previous rise of e
    } row_t;

    row_t      expected [num_rows];
    logic      clkout;
    logic      reset;
    lcd_byte_t data;
    logic      e;
    logic      rs;
    logic      r_nw;
    logic      armed;
    lcd_byte_t exp_data;
    logic      exp_rs;
    int        exp_gap;
    logic      idle_req;
    int        tests_done;
    int        pass_count;
    int        fail_count;
    int        expected_tests;
    int        seed;
    logic      table_ready;
    int        pass_no;
    int        row;

    lcd_top #(
        .delay_cycles (delay)
    ) dut (
        .clkout (clkout),
        .reset  (reset),
        .data   (data),
        .e      (e),
        .rs     (rs),
        .r_nw   (r_nw)
    );

    lcd_bus_checker bus_check (
        .clkout     (clkout),
        .reset      (reset),
        .data       (data),
        .e          (e),
        .rs         (rs),
        .r_nw       (r_nw),
        .armed      (armed),
        .exp_data   (exp_data),
        .exp_rs     (exp_rs),
        .exp_gap    (exp_gap),
        .idle_req   (idle_req),
        .tests_done (tests_done),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    always #2 clkout = ~clkout;

    task automatic fill_table();
        string text;
        int    i;
        text = "HELLO WORLD";
        expected[0] = '{data: 8'h3C, rs: 1'b0, gap: delay + 2};  // from release
        expected[1] = '{data: 8'h3C, rs: 1'b0, gap: delay + 1};
        expected[2] = '{data: 8'h0F, rs: 1'b0, gap: delay + 1};
        expected[3] = '{data: 8'h01, rs: 1'b0, gap: delay + 1};
        for (i = 0; i < text.len(); i = i + 1)
            expected[4 + i] = '{data: text[i], rs: 1'b1, gap: delay + 1};
        expected[4].gap = 2 * delay + 1;    // settle delay after clear
    endtask

    function automatic int total_gap();
        int sum;
        int i;
        sum = 0;
        for (i = 0; i < num_rows; i = i + 1)
            sum = sum + expected[i].gap;
        return sum;
    endfunction

    task automatic hold_reset();
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clkout);
        #1;
        reset = 1'b0;
        expected_tests = expected_tests + 1;    // pin check while in reset
    endtask

    // hand one row to the checker and wait until it has scored the pulse
    task automatic play_row(input int idx);
        int base;
        exp_data = expected[idx].data;
        exp_rs   = expected[idx].rs;
        exp_gap  = expected[idx].gap;
        armed    = 1'b1;
        base     = tests_done;
        wait (tests_done > base);
        #1;
        armed = 1'b0;
        expected_tests = expected_tests + 1;
    endtask

    task automatic watch_idle();
        int base;
        exp_data = expected[num_rows - 1].data;
        exp_gap  = 3 * delay;
        repeat (3 * delay) @(posedge clkout);
        #1;
        idle_req = 1'b1;
        base     = tests_done;
        wait (tests_done > base);
        #1;
        idle_req = 1'b0;
        expected_tests = expected_tests + 1;
    endtask

    // reset at a random cycle somewhere between the first and the last pulse
    task automatic interrupt_run();
        int span;
        int cut;
        int cum;
        int k;
        int i;
        span = total_gap() - expected[0].gap - 1;
        cut  = expected[0].gap + 1 + int'({$random(seed)} % span);
        cum  = 0;
        for (i = 0; i < num_rows; i = i + 1)
        begin
            cum = cum + expected[i].gap;
            if (cum == cut)
                cut = cut - 1;    // land between two rises
        end
        $display("mid-run reset %0d cycles after release", cut);
        cum = 0;
        k   = 0;
        while (cum + expected[k].gap < cut)
        begin
            play_row(k);
            cum = cum + expected[k].gap;
            k   = k + 1;
        end
        if (cut - cum - 1 > 0)
        begin
            repeat (cut - cum - 1) @(posedge clkout);
            #1;
        end
        armed = 1'b0;
        hold_reset();
    endtask

    initial
    begin
        clkout         = 1'b0;
        reset          = 1'b1;
        armed          = 1'b0;
        exp_data       = '0;
        exp_rs         = 1'b0;
        exp_gap        = 0;
        idle_req       = 1'b0;
        expected_tests = 0;
        seed           = 3;
        table_ready    = 1'b0;
        fill_table();
        table_ready = 1'b1;

        for (pass_no = 0; pass_no < 2; pass_no = pass_no + 1)
        begin
            hold_reset();
            if (pass_no == 1)
                interrupt_run();    // checker starts over at row 0 afterwards
            for (row = 0; row < num_rows; row = row + 1)
                play_row(row);
            watch_idle();
        end

        repeat (2) @(posedge clkout);
        if (pass_count + fail_count != expected_tests)
            $display("expected %0d tests but %0d finished", expected_tests,
                     pass_count + fail_count);
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == expected_tests)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        int limit;
        wait (table_ready);
        // two full runs, one cut short, two idle watches and the resets
        limit = 3 * total_gap() + 2 * (3 * delay + 2) + 3 * (reset_cycles + 1) + 200;
        #(limit * clk_period);
        $display("watchdog expired after %0d cycles, the LCD sequence did not finish", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+rtl
rtl/lcd_pkg.sv
rtl/lcd_delay_timer.sv
rtl/lcd_step_rom.sv
rtl/lcd_sequencer.sv
rtl/lcd_top.sv
verification/lcd_bus_checker.sv
verification/lcd_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the LCD testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f files.f --top-module lcd_tb -o lcd_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/lcd_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
